// File: rtl/dsp_settings.svh
////////////////////////////////////////
// shared settings for the morse filter
// sample and coefficient widths, tap count,
// scaling shift and morse decision windows
////////////////////////////////////////

`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// width of one serial sample and of one filtered result
`define SAMPLE_BITS 16

// filter length and coefficient format
`define NUM_TAPS 16
`define COEF_BITS 16

// the coefficients are Q15, so the sum is shifted back by 15
`define COEF_FRAC 15

// 32 bit products summed over 16 taps need 36 bits plus some headroom
`define ACC_BITS 40

// inclusive level windows on the filtered value
`define DASH_LO 90
`define DASH_HI 110
`define DOT_LO 40
`define DOT_HI 60

`endif

// File: rtl/stream_pkg.sv
////////////////////////////////////////
// stream types between the blocks
// sample word and the beats that carry
// samples and filtered results
////////////////////////////////////////

`include "dsp_settings.svh"

package stream_pkg;

	// one signed sample word, also the width of a filtered result
	typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

	////////////////////////////////////////
	// beats
	////////////////////////////////////////

	// deserialized sample toward the filter
	// valid is a single cycle pulse
	typedef struct packed
	{
		logic    valid;
		sample_t data;
	} sample_beat_t;

	// filtered value toward the serializer and the detector
	// valid is a single cycle pulse
	typedef struct packed
	{
		logic    valid;
		sample_t data;
	} result_beat_t;

endpackage

// File: rtl/filter_pkg.sv
////////////////////////////////////////
// filter arithmetic types
// coefficient, product, accumulator,
// tap index and coefficient file name
////////////////////////////////////////

`include "dsp_settings.svh"

package filter_pkg;

	// signed Q15 coefficient as stored in the hex file
	typedef logic signed [`COEF_BITS-1:0] coef_t;

	// full precision coefficient times sample
	typedef logic signed [`COEF_BITS+`SAMPLE_BITS-1:0] product_t;

	// running sum over all taps
	typedef logic signed [`ACC_BITS-1:0] acc_t;

	////////////////////////////////////////
	// tap addressing
	////////////////////////////////////////

	localparam int TAP_BITS = $clog2(`NUM_TAPS);

	typedef logic [TAP_BITS-1:0] tap_index_t;

	// one hex word per line, tap 0 first
	// tap 0 weights the newest sample
	localparam string COEF_FILE = "rtl/fir_coeffs.hex";

endpackage

// File: rtl/serial_sample_rx.sv
////////////////////////////////////////
// serial sample receiver
// shifts in strobed bits msb first and
// emits a sample beat when the strobe drops
////////////////////////////////////////

`timescale 1ns/1ps
`include "dsp_settings.svh"

module serial_sample_rx
	import stream_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         sample_strobe,
	input  logic         sample_bit,
	output sample_beat_t sample_out
);

	// one count past a full sample marks an overlong burst
	localparam int CNT_BITS = $clog2(`SAMPLE_BITS + 2);
	localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(`SAMPLE_BITS);
	localparam logic [CNT_BITS-1:0] OVER_COUNT = CNT_BITS'(`SAMPLE_BITS + 1);

	logic [CNT_BITS-1:0] bit_count;
	sample_t             shift_q;

	////////////////////////////////////////
	// bit counter
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_count <= '0;
		end
		else if (sample_strobe)
		begin
			// stick at the overflow value so a long burst never wraps to full
			if (bit_count != OVER_COUNT)
			begin
				bit_count <= bit_count + 1'b1;
			end
		end
		else
		begin
			bit_count <= '0;
		end
	end

	// sample shift register, msb arrives first
	always_ff @(posedge clk)
	begin
		if (sample_strobe)
		begin
			shift_q <= {shift_q[`SAMPLE_BITS-2:0], sample_bit};
		end
	end

	////////////////////////////////////////
	// beat output
	////////////////////////////////////////

	// valid only in the first low cycle, the count clears right after
	always_comb
	begin
		sample_out.valid = !sample_strobe && (bit_count == FULL_COUNT);
		sample_out.data  = shift_q;
	end

endmodule

// File: rtl/fir_mac.sv
////////////////////////////////////////
// sequential fir filter
// delay line, coefficient rom, one shared
// multiplier, scaling and saturation
////////////////////////////////////////

`timescale 1ns/1ps
`include "dsp_settings.svh"

module fir_mac
	import stream_pkg::*;
	import filter_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  sample_beat_t sample_in,
	output result_beat_t result_out
);

	localparam acc_t SAT_MAX = acc_t'((1 <<< (`SAMPLE_BITS - 1)) - 1);
	localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);
	localparam tap_index_t LAST_TAP = tap_index_t'(`NUM_TAPS - 1);

	coef_t      coef_rom [`NUM_TAPS];
	sample_t    delay_line [`NUM_TAPS];
	tap_index_t tap;
	logic       busy;
	logic       done;
	acc_t       acc;
	product_t   product;
	acc_t       scaled;

	initial
	begin
		$readmemh(COEF_FILE, coef_rom);
	end

	////////////////////////////////////////
	// delay line
	////////////////////////////////////////

	// newest sample lands in position 0
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `NUM_TAPS; i++)
			begin
				delay_line[i] <= '0;
			end
		end
		else if (sample_in.valid)
		begin
			delay_line[0] <= sample_in.data;
			for (int i = 1; i < `NUM_TAPS; i++)
			begin
				delay_line[i] <= delay_line[i-1];
			end
		end
	end

	////////////////////////////////////////
	// multiply accumulate
	////////////////////////////////////////

	// coefficient k always meets delay position k
	assign product = product_t'(coef_rom[tap]) * product_t'(delay_line[tap]);

	// one tap per cycle and done flags the cycle after the last add
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			tap  <= '0;
			acc  <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (sample_in.valid)
			begin
				busy <= 1'b1;
				tap  <= '0;
				acc  <= '0;
			end
			else if (busy)
			begin
				acc <= acc + acc_t'(product);
				tap <= tap + 1'b1;
				if (tap == LAST_TAP)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// scaling and saturation
	////////////////////////////////////////

	assign scaled = acc >>> `COEF_FRAC;

	always_comb
	begin
		result_out.valid = done;
		if (scaled > SAT_MAX)
		begin
			result_out.data = sample_t'(SAT_MAX);
		end
		else if (scaled < SAT_MIN)
		begin
			result_out.data = sample_t'(SAT_MIN);
		end
		else
		begin
			result_out.data = sample_t'(scaled);
		end
	end

	// the receiver must leave a whole pass between samples
	a_no_overlap: assert property (@(posedge clk) disable iff (!reset)
		sample_in.valid |-> !busy);

endmodule

// File: rtl/serial_result_tx.sv
////////////////////////////////////////
// serial result transmitter
// shifts a filtered value out lsb first
// with one clk_out toggle per bit
////////////////////////////////////////

`timescale 1ns/1ps
`include "dsp_settings.svh"

module serial_result_tx
	import stream_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  result_beat_t result_in,
	output logic         data_out,
	output logic         clk_out
);

	localparam int CNT_BITS = $clog2(`SAMPLE_BITS + 1);
	localparam logic [CNT_BITS-1:0] LOAD_COUNT = CNT_BITS'(`SAMPLE_BITS - 1);

	logic [CNT_BITS-1:0]     bits_left;
	logic [`SAMPLE_BITS-1:0] shift_q;

	////////////////////////////////////////
	// bit sequencing
	////////////////////////////////////////

	// bit 0 goes out with the load, the rest follow one per cycle
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bits_left <= '0;
			data_out  <= 1'b0;
			clk_out   <= 1'b0;
		end
		else if (result_in.valid)
		begin
			bits_left <= LOAD_COUNT;
			data_out  <= result_in.data[0];
			clk_out   <= ~clk_out;
		end
		else if (bits_left != '0)
		begin
			bits_left <= bits_left - 1'b1;
			data_out  <= shift_q[0];
			clk_out   <= ~clk_out;
		end
	end

	// remaining bits, next one always in position 0
	always_ff @(posedge clk)
	begin
		if (result_in.valid)
		begin
			shift_q <= result_in.data >> 1;
		end
		else if (bits_left != '0)
		begin
			shift_q <= shift_q >> 1;
		end
	end

	// the filter may not finish a pass while a word is still going out
	a_no_overrun: assert property (@(posedge clk) disable iff (!reset)
		result_in.valid |-> (bits_left == '0));

endmodule

// File: rtl/morse_level_detect.sv
////////////////////////////////////////
// morse level detector
// dash window sets, dot window clears
////////////////////////////////////////

`timescale 1ns/1ps
`include "dsp_settings.svh"

module morse_level_detect
	import stream_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  result_beat_t result_in,
	output logic         dash_led
);

	logic in_dash;
	logic in_dot;

	// inclusive window compares on the signed result
	assign in_dash = (result_in.data >= `DASH_LO) && (result_in.data <= `DASH_HI);
	assign in_dot  = (result_in.data >= `DOT_LO) && (result_in.data <= `DOT_HI);

	// values outside both windows leave the indicator alone
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			dash_led <= 1'b0;
		end
		else if (result_in.valid)
		begin
			if (in_dash)
			begin
				dash_led <= 1'b1;
			end
			else if (in_dot)
			begin
				dash_led <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/morse_filter_top.sv
////////////////////////////////////////
// morse filter front end top level
// receiver, fir, transmitter, detector
////////////////////////////////////////

`timescale 1ns/1ps

module morse_filter_top
	import stream_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sample_strobe,
	input  logic sample_bit,
	output logic data_out,
	output logic clk_out,
	output logic dash_led
);

	sample_beat_t sample_beat;
	result_beat_t result_beat;

	// serial input to sample words
	serial_sample_rx serial_sample_rx_i (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample_bit    (sample_bit),
		.sample_out    (sample_beat)
	);

	fir_mac fir_mac_i (
		.clk        (clk),
		.reset      (reset),
		.sample_in  (sample_beat),
		.result_out (result_beat)
	);

	// both consumers see the same result beat
	serial_result_tx serial_result_tx_i (
		.clk       (clk),
		.reset     (reset),
		.result_in (result_beat),
		.data_out  (data_out),
		.clk_out   (clk_out)
	);

	morse_level_detect morse_level_detect_i (
		.clk       (clk),
		.reset     (reset),
		.result_in (result_beat),
		.dash_led  (dash_led)
	);

endmodule

// File: verification/morse_filter_tb.sv
////////////////////////////////////////
// testbench for the morse filter top
// seeded serial stimulus, reference fir and
// detector model, serial capture, watchdog
////////////////////////////////////////

`timescale 1ns/1ps
`include "dsp_settings.svh"

module morse_filter_tb
	import stream_pkg::*;
	import filter_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int MIN_GAP = `NUM_TAPS + 2;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_SHORT = 4;
	localparam int TOTAL_SAMPLES = NUM_RANDOM + 2 * NUM_SHORT + 32 + 80;
	localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * (`SAMPLE_BITS + `NUM_TAPS + 40) + 20;
	localparam longint MAX_SAMPLE = (longint'(1) <<< (`SAMPLE_BITS - 1)) - 1;
	localparam longint MIN_SAMPLE = -MAX_SAMPLE - 1;

	logic clk = 1'b0;
	logic reset;
	logic sample_strobe;
	logic sample_bit;
	logic data_out;
	logic clk_out;
	logic dash_led;

	// reference model state
	coef_t   model_coef [`NUM_TAPS];
	sample_t model_line [`NUM_TAPS];
	logic    model_dash;
	sample_t last_model_result;
	logic    hit_dash;
	logic    hit_dot;
	logic    hit_neither;

	// expected results in send order
	sample_t exp_results [$];
	logic    exp_dashes [$];
	int      exp_starts [$];
	int      results_expected;
	int      results_seen;
	int      cycle_count;

	// capture state
	logic    last_clk_out;
	int      bit_index;
	sample_t got_word;
	sample_t cur_result;
	logic    cur_dash;

	morse_filter_top morse_filter_top_i (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample_bit    (sample_bit),
		.data_out      (data_out),
		.clk_out       (clk_out),
		.dash_led      (dash_led)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
	end

	////////////////////////////////////////
	// error reporting and compare tasks
	////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_result(input sample_t got, input sample_t exp);
		if (got !== exp)
		begin
			stop_on_error($sformatf("FAILED data_out word: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic check_dash(input logic got, input logic exp);
		if (got !== exp)
		begin
			stop_on_error($sformatf("FAILED dash_led: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic check_silence(input logic data_v, input logic clk_v, input logic dash_v);
		if (data_v !== 1'b0)
		begin
			stop_on_error($sformatf("FAILED data_out idle: got 0x%h, expected 0x0", data_v));
		end
		else if (clk_v !== 1'b0)
		begin
			stop_on_error($sformatf("FAILED clk_out idle: got 0x%h, expected 0x0", clk_v));
		end
		else if (dash_v !== 1'b0)
		begin
			stop_on_error($sformatf("FAILED dash_led idle: got 0x%h, expected 0x0", dash_v));
		end
	endtask

	////////////////////////////////////////
	// reference model and stimulus
	////////////////////////////////////////

	// newest in position 0, sum scaled by an arithmetic shift then clamped
	task automatic model_push(input sample_t value);
		longint sum;
		longint scaled;
		sample_t res;
		for (int i = `NUM_TAPS - 1; i > 0; i--)
		begin
			model_line[i] = model_line[i-1];
		end
		model_line[0] = value;
		sum = 0;
		for (int k = 0; k < `NUM_TAPS; k++)
		begin
			sum = sum + longint'(model_coef[k]) * longint'(model_line[k]);
		end
		scaled = sum >>> `COEF_FRAC;
		if (scaled > MAX_SAMPLE)
			res = sample_t'(MAX_SAMPLE);
		else if (scaled < MIN_SAMPLE)
			res = sample_t'(MIN_SAMPLE);
		else
			res = sample_t'(scaled);
		if (res >= `DASH_LO && res <= `DASH_HI)
		begin
			model_dash = 1'b1;
			hit_dash = 1'b1;
		end
		else if (res >= `DOT_LO && res <= `DOT_HI)
		begin
			model_dash = 1'b0;
			hit_dot = 1'b1;
		end
		else
		begin
			hit_neither = 1'b1;
		end
		last_model_result = res;
		exp_results.push_back(res);
		exp_dashes.push_back(model_dash);
		exp_starts.push_back(cycle_count + `NUM_TAPS + 2);
		results_expected++;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			sample_strobe = 1'b0;
			sample_bit = 1'b0;
		end
	endtask

	// msb first, the model sees the sample when the strobe drops
	task automatic send_burst(input sample_t value, input int num_bits);
		for (int i = `SAMPLE_BITS - 1; i >= `SAMPLE_BITS - num_bits; i--)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			sample_strobe = 1'b1;
			sample_bit = value[i];
		end
		@(posedge clk);
		#DRIVE_DELAY;
		sample_strobe = 1'b0;
		sample_bit = 1'b0;
		if (num_bits == `SAMPLE_BITS)
		begin
			model_push(value);
		end
	endtask

	task automatic send_repeated(input sample_t value, input int count);
		repeat (count)
		begin
			send_burst(value, `SAMPLE_BITS);
			idle_cycles(MIN_GAP);
		end
	endtask

	////////////////////////////////////////
	// serial capture
	////////////////////////////////////////

	always @(posedge clk)
	begin
		#1;
		if (clk_out !== last_clk_out)
		begin
			last_clk_out = clk_out;
			if (bit_index == 0 && exp_results.size() == 0)
			begin
				stop_on_error("clk_out toggled while no result was pending");
			end
			else if (bit_index == 0 && cycle_count != exp_starts[0])
			begin
				stop_on_error($sformatf("result bit 0 came at cycle %0d instead of %0d",
					cycle_count, exp_starts[0]));
			end
			else
			begin
				if (bit_index == 0)
				begin
					cur_result = exp_results.pop_front();
					cur_dash = exp_dashes.pop_front();
					void'(exp_starts.pop_front());
					check_dash(dash_led, cur_dash);
				end
				got_word[bit_index] = data_out;
				bit_index++;
				if (bit_index == `SAMPLE_BITS)
				begin
					check_result(got_word, cur_result);
					bit_index = 0;
					results_seen++;
				end
			end
		end
		else if (bit_index != 0)
		begin
			stop_on_error("clk_out stopped before all bits of a result were sent");
		end
		else if (exp_starts.size() != 0 && cycle_count > exp_starts[0])
		begin
			stop_on_error("no result appeared for a received sample");
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_on_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		reset = 1'b0;
		sample_strobe = 1'b0;
		sample_bit = 1'b0;
		model_dash = 1'b0;
		cycle_count = 0;
		results_expected = 0;
		results_seen = 0;
		last_clk_out = 1'b0;
		bit_index = 0;
		for (int i = 0; i < `NUM_TAPS; i++)
		begin
			model_line[i] = '0;
		end
		$readmemh(COEF_FILE, model_coef);
		void'($urandom(32'h8a6b1e7f));
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b1;

		// idle outputs before any sample
		repeat (8)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_silence(data_out, clk_out, dash_led);
		end

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			send_burst(sample_t'($urandom), `SAMPLE_BITS);
			idle_cycles(MIN_GAP + $urandom_range(0, 7));
		end

		// short bursts are dropped, the next full sample must still match
		for (int n = 0; n < NUM_SHORT; n++)
		begin
			send_burst(sample_t'($urandom), $urandom_range(1, `SAMPLE_BITS - 1));
			idle_cycles(MIN_GAP);
			send_burst(sample_t'($urandom), `SAMPLE_BITS);
			idle_cycles(MIN_GAP);
		end

		// full scale with signs matched to the coefficients, both polarities
		send_repeated(16'sh8000, 3);
		send_repeated(16'sh7fff, 10);
		send_repeated(16'sh8000, 3);
		if (last_model_result !== 16'sh7fff)
			stop_on_error("positive full scale pattern did not saturate the model");
		send_repeated(16'sh7fff, 3);
		send_repeated(16'sh8000, 10);
		send_repeated(16'sh7fff, 3);
		if (last_model_result !== 16'sh8000)
			stop_on_error("negative full scale pattern did not saturate the model");

		// dc gain is one, so held levels settle on the level itself
		hit_dash = 1'b0;
		hit_dot = 1'b0;
		hit_neither = 1'b0;
		send_repeated(16'sd100, 16);
		send_repeated(16'sd75, 16);
		send_repeated(16'sd50, 16);
		send_repeated(16'sd75, 16);
		send_repeated(16'sd100, 16);
		if (!(hit_dash && hit_dot && hit_neither))
			stop_on_error("morse sequences did not reach every window in the model");

		wait (results_seen == results_expected);
		idle_cycles(40);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/filter_pkg.sv
rtl/serial_sample_rx.sv
rtl/fir_mac.sv
rtl/serial_result_tx.sv
rtl/morse_level_detect.sv
rtl/morse_filter_top.sv
verification/morse_filter_tb.sv

// File: rtl/fir_coeffs.hex
// one signed Q15 coefficient per line in hex, tap 0 (newest sample) first
FE00
FC00
FD00
0300
0900
1000
1300
1A00
1A00
1300
1000
0900
0300
FD00
FC00
FE00
